//--- src.f
icap_pkg.sv
frame_cfg_regs.sv
icap_write_seq.sv
icap_frame_writer.sv
tb_icap_port_model.sv
tb_icap_frame_writer.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing \
    -Wno-fatal \
    --top-module tb_icap_frame_writer \
    -f src.f \
    -o sim_tb

./obj_dir/sim_tb

//--- tb_icap_frame_writer.sv
`timescale 1ns/1ps

module tb_icap_frame_writer;

    localparam int STREAM_LEN   = icap_pkg::FRAME_WORDS + 20;   // enabled words per write
    localparam int RANDOM_TXNS  = 10;
    localparam int DONE_TIMEOUT = 16;

    logic                        clk;
    logic                        rst_n;
    logic                        start_i;
    logic                        load_addr_i;
    logic [icap_pkg::ICAP_W-1:0] frame_addr_i;
    logic [icap_pkg::ICAP_W-1:0] fill_word_i;
    logic                        csib_o;
    logic                        rdwrb_o;
    logic [icap_pkg::ICAP_W-1:0] icap_data_o;
    logic                        busy_o;
    logic                        done_o;
    logic [icap_pkg::ICAP_W-1:0] frame_addr_o;

    logic                        m_accept;
    logic                        m_step;
    logic [7:0]                  m_idx;
    logic [icap_pkg::ICAP_W-1:0] exp_addr;
    logic [icap_pkg::ICAP_W-1:0] exp_word;

    integer seed;

    icap_frame_writer dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .load_addr_i  (load_addr_i),
        .frame_addr_i (frame_addr_i),
        .fill_word_i  (fill_word_i),
        .csib_o       (csib_o),
        .rdwrb_o      (rdwrb_o),
        .icap_data_o  (icap_data_o),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .frame_addr_o (frame_addr_o)
    );

    tb_icap_port_model ref_model0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept_i   (m_accept),
        .load_i     (load_addr_i),
        .addr_i     (frame_addr_i),
        .fill_i     (fill_word_i),
        .step_i     (m_step),
        .word_idx_i (m_idx),
        .exp_addr_o (exp_addr),
        .exp_word_o (exp_word)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [icap_pkg::ICAP_W-1:0] got,
                              input logic [icap_pkg::ICAP_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_ctrl(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_cycle(input logic csib, input logic rdwrb, input logic busy,
                               input logic done);
        check_ctrl("csib_o", csib_o, csib);
        check_ctrl("rdwrb_o", rdwrb_o, rdwrb);
        check_ctrl("busy_o", busy_o, busy);
        check_ctrl("done_o", done_o, done);
        check_word("frame_addr_o", frame_addr_o, exp_addr);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    // random data inputs with optional stray starts
    task automatic drive_inputs(input bit strays);
        logic [31:0] r;
        r            = $random(seed);
        start_i      = strays && (r[3:0] == 4'h0);
        load_addr_i  = r[4];
        frame_addr_i = $random(seed);
        fill_word_i  = $random(seed);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            m_step = 1'b0;
            check_cycle(1'b1, 1'b1, 1'b0, 1'b0);
            drive_inputs(1'b0);
        end
    endtask

    task automatic wait_done(output int waited);
        waited = 0;
        while (done_o !== 1'b1) begin
            if (waited == DONE_TIMEOUT) begin
                abort_run($sformatf("done_o never arrived within %0d cycles", DONE_TIMEOUT));
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // called on a negedge while idle, returns on the done cycle
    task automatic run_write(input logic load, input logic [31:0] addr,
                             input logic [31:0] fill, input bit strays);
        int waited;
        int k;
        start_i      = 1'b1;
        load_addr_i  = load;
        frame_addr_i = addr;
        fill_word_i  = fill;
        m_accept     = 1'b1;
        @(negedge clk);
        m_accept = 1'b0;
        m_step   = 1'b0;
        check_cycle(1'b1, 1'b1, 1'b1, 1'b0);               // outputs trail by one edge
        drive_inputs(strays);
        m_idx = 8'd0;
        @(negedge clk);
        check_cycle(1'b1, 1'b0, 1'b1, 1'b0);               // select cycle
        drive_inputs(strays);
        for (k = 0; k < STREAM_LEN; k++) begin
            @(negedge clk);
            check_cycle(1'b0, 1'b0, 1'b1, 1'b0);
            check_word($sformatf("icap_data_o word %0d", k), icap_data_o, exp_word);
            drive_inputs(strays);
            m_idx = 8'(k + 1);
        end
        wait_done(waited);
        check_word("done latency", 32'(waited), 32'd1);
        check_cycle(1'b1, 1'b1, 1'b0, 1'b1);
        m_step = 1'b1;                                     // address steps on the next edge
        drive_inputs(1'b0);
    endtask

    initial begin
        int          txn;
        int          gap;
        logic [31:0] r;
        seed         = 32'h74ef_21a7;
        rst_n        = 1'b0;
        start_i      = 1'b0;
        load_addr_i  = 1'b0;
        frame_addr_i = '0;
        fill_word_i  = '0;
        m_accept     = 1'b0;
        m_step       = 1'b0;
        m_idx        = 8'd0;
        repeat (10) @(negedge clk);
        check_cycle(1'b1, 1'b1, 1'b0, 1'b0);
        check_word("icap_data_o in reset", icap_data_o, '0);
        rst_n = 1'b1;
        idle_cycles(3);

        run_write(1'b1, $random(seed), $random(seed), 1'b0);   // plain loaded write
        idle_cycles(2);
        run_write(1'b1, $random(seed), $random(seed), 1'b1);   // starts while busy
        idle_cycles(4);

        // writes without load where the first starts in the done cycle
        run_write(1'b0, $random(seed), $random(seed), 1'b0);
        run_write(1'b0, $random(seed), $random(seed), 1'b0);
        idle_cycles(1);
        run_write(1'b0, $random(seed), $random(seed), 1'b1);

        for (txn = 0; txn < RANDOM_TXNS; txn++) begin
            gap = $random(seed) & 3;
            idle_cycles(gap);
            r = $random(seed);
            run_write(r[0], $random(seed), $random(seed), r[1]);
        end
        idle_cycles(6);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- tb_icap_port_model.sv
`timescale 1ns/1ps

module tb_icap_port_model (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         accept_i,     // start the tb expects to be taken
    input  logic                         load_i,
    input  logic [icap_pkg::ICAP_W-1:0] addr_i,
    input  logic [icap_pkg::ICAP_W-1:0] fill_i,
    input  logic                         step_i,       // write just finished
    input  logic [7:0]                   word_idx_i,   // position in the enabled stream
    output logic [icap_pkg::ICAP_W-1:0] exp_addr_o,
    output logic [icap_pkg::ICAP_W-1:0] exp_word_o
);

    localparam int FILL_FIRST = 14;                              // after the FDRI header
    localparam int FILL_LAST  = FILL_FIRST + icap_pkg::FRAME_WORDS - 1;

    logic [icap_pkg::ICAP_W-1:0] addr_q;
    logic [icap_pkg::ICAP_W-1:0] fill_q;
    logic [icap_pkg::ICAP_W-1:0] plain;

    // bit i of a byte goes to bit 7-i of the same byte
    function automatic logic [31:0] mirror_bytes(input logic [31:0] w);
        logic [31:0] m;
        int i;
        for (i = 0; i < 32; i++) begin
            m[i] = w[(i / 8) * 8 + 7 - (i % 8)];
        end
        return m;
    endfunction

    ////////////////////////////////////////////////////////////
    // expected frame address and fill word
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            fill_q <= '0;
        end else begin
            if (accept_i && load_i) begin
                addr_q <= addr_i;
            end else if (step_i) begin
                addr_q <= addr_q + 32'd1;                   // next frame
            end
            if (accept_i) begin
                fill_q <= fill_i;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // expected port word
    ////////////////////////////////////////////////////////////
    always_comb begin
        int tail;
        tail = int'(word_idx_i) - FILL_LAST - 1;            // index inside the trailer
        if (int'(word_idx_i) < FILL_FIRST) begin
            case (word_idx_i)
                8'd1:                 plain = 32'hFFFF_FFFF;
                8'd2:                 plain = 32'hAA99_5566;   // sync
                8'd3, 8'd4, 8'd5,
                8'd10:                plain = 32'h2000_0000;
                8'd6:                 plain = 32'h3001_8001;
                8'd7:                 plain = 32'h0362_D093;   // idcode
                8'd8:                 plain = 32'h3000_8001;
                8'd9:                 plain = 32'h0000_0001;   // wcfg
                8'd11:                plain = 32'h3000_2001;
                8'd12:                plain = addr_q;
                8'd13:                plain = 32'h3000_4000 | 32'(icap_pkg::FRAME_WORDS);
                default:              plain = '0;              // leading zero word
            endcase
        end else if (int'(word_idx_i) <= FILL_LAST) begin
            plain = fill_q;
        end else begin
            case (tail)
                0, 1, 4, 5:           plain = 32'h2000_0000;
                2:                    plain = 32'h3000_8001;
                3:                    plain = 32'h0000_000D;   // desync
                default:              plain = '0;
            endcase
        end
        exp_word_o = mirror_bytes(plain);
    end

    assign exp_addr_o = addr_q;

endmodule

//--- icap_frame_writer.sv
`timescale 1ns/1ps

module icap_frame_writer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,          // one-cycle strobe
    input  logic                         load_addr_i,
    input  logic [icap_pkg::ICAP_W-1:0] frame_addr_i,
    input  logic [icap_pkg::ICAP_W-1:0] fill_word_i,
    output logic                         csib_o,           // active-low port enable
    output logic                         rdwrb_o,          // 0 = write
    output logic [icap_pkg::ICAP_W-1:0] icap_data_o,      // bit-reversed per byte
    output logic                         busy_o,
    output logic                         done_o,
    output logic [icap_pkg::ICAP_W-1:0] frame_addr_o
);

    logic                        start_accept;
    logic                        frame_done;
    logic [icap_pkg::ICAP_W-1:0] frame_addr;
    logic [icap_pkg::ICAP_W-1:0] fill_word;

    ////////////////////////////////////////////////////////////
    // address and fill word storage
    ////////////////////////////////////////////////////////////
    frame_cfg_regs u_cfg (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_accept_i (start_accept),
        .frame_done_i   (frame_done),
        .load_addr_i    (load_addr_i),
        .frame_addr_i   (frame_addr_i),
        .fill_word_i    (fill_word_i),
        .frame_addr_o   (frame_addr),
        .fill_word_o    (fill_word)
    );

    ////////////////////////////////////////////////////////////
    // write sequencer
    ////////////////////////////////////////////////////////////
    icap_write_seq u_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .frame_addr_i   (frame_addr),
        .fill_word_i    (fill_word),
        .start_accept_o (start_accept),
        .frame_done_o   (frame_done),
        .busy_o         (busy_o),
        .csib_o         (csib_o),
        .rdwrb_o        (rdwrb_o),
        .icap_data_o    (icap_data_o)
    );

    assign done_o       = frame_done;
    assign frame_addr_o = frame_addr;

endmodule

//--- icap_write_seq.sv
`timescale 1ns/1ps

module icap_write_seq (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic [icap_pkg::ICAP_W-1:0] frame_addr_i,
    input  logic [icap_pkg::ICAP_W-1:0] fill_word_i,
    output logic                         start_accept_o,
    output logic                         frame_done_o,
    output logic                         busy_o,
    output logic                         csib_o,
    output logic                         rdwrb_o,
    output logic [icap_pkg::ICAP_W-1:0] icap_data_o
);

    icap_pkg::seq_state_e state_q;
    icap_pkg::seq_state_e state_d;

    logic [icap_pkg::WORD_CNT_W-1:0] cnt_q;          // cycles spent in current state
    logic [icap_pkg::ICAP_W-1:0]     word_sel;       // plain word for this state

    logic                        csib_q;
    logic                        rdwrb_q;
    logic [icap_pkg::ICAP_W-1:0] data_q;
    logic                        last_q;             // last enabled word just registered
    logic                        done_q;

    ////////////////////////////////////////////////////////////
    // start acceptance
    ////////////////////////////////////////////////////////////
    // busy also covers the final enabled word, which is still
    // on the port after the fsm has gone back to idle
    assign busy_o         = (state_q != icap_pkg::ST_IDLE) || !csib_q;
    assign start_accept_o = start_i && !busy_o;

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            icap_pkg::ST_IDLE:       if (start_accept_o) state_d = icap_pkg::ST_SELECT;
            icap_pkg::ST_SELECT:     state_d = icap_pkg::ST_PREAMBLE;
            icap_pkg::ST_PREAMBLE:   state_d = icap_pkg::ST_DUMMY;
            icap_pkg::ST_DUMMY:      state_d = icap_pkg::ST_SYNC;
            icap_pkg::ST_SYNC:       state_d = icap_pkg::ST_NOOP_A;
            icap_pkg::ST_NOOP_A: begin
                if (cnt_q == icap_pkg::NOOP_A_LAST) state_d = icap_pkg::ST_IDCODE_HDR;
            end
            icap_pkg::ST_IDCODE_HDR: state_d = icap_pkg::ST_IDCODE;
            icap_pkg::ST_IDCODE:     state_d = icap_pkg::ST_CMD_HDR;
            icap_pkg::ST_CMD_HDR:    state_d = icap_pkg::ST_WCFG;
            icap_pkg::ST_WCFG:       state_d = icap_pkg::ST_NOOP_B;
            icap_pkg::ST_NOOP_B:     state_d = icap_pkg::ST_FAR_HDR;
            icap_pkg::ST_FAR_HDR:    state_d = icap_pkg::ST_FAR;
            icap_pkg::ST_FAR:        state_d = icap_pkg::ST_FDRI_HDR;
            icap_pkg::ST_FDRI_HDR:   state_d = icap_pkg::ST_FRAME_DATA;
            icap_pkg::ST_FRAME_DATA: begin
                if (cnt_q == icap_pkg::FRAME_LAST) state_d = icap_pkg::ST_NOOP_C;
            end
            icap_pkg::ST_NOOP_C: begin
                if (cnt_q == icap_pkg::NOOP_C_LAST) state_d = icap_pkg::ST_DESYNC_HDR;
            end
            icap_pkg::ST_DESYNC_HDR: state_d = icap_pkg::ST_DESYNC;
            icap_pkg::ST_DESYNC:     state_d = icap_pkg::ST_NOOP_D;
            icap_pkg::ST_NOOP_D: begin
                if (cnt_q == icap_pkg::NOOP_D_LAST) state_d = icap_pkg::ST_IDLE;
            end
            default:                 state_d = icap_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= icap_pkg::ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q) begin
                cnt_q <= '0;                            // restart on every state change
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // port word select
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (state_q)
            icap_pkg::ST_DUMMY:      word_sel = icap_pkg::DUMMY_WORD;
            icap_pkg::ST_SYNC:       word_sel = icap_pkg::SYNC_WORD;
            icap_pkg::ST_NOOP_A,
            icap_pkg::ST_NOOP_B,
            icap_pkg::ST_NOOP_C,
            icap_pkg::ST_NOOP_D:     word_sel = icap_pkg::NOOP_WORD;
            icap_pkg::ST_IDCODE_HDR: word_sel = icap_pkg::IDCODE_HDR;
            icap_pkg::ST_IDCODE:     word_sel = icap_pkg::DEVICE_IDCODE;
            icap_pkg::ST_CMD_HDR,
            icap_pkg::ST_DESYNC_HDR: word_sel = icap_pkg::CMD_HDR;
            icap_pkg::ST_WCFG:       word_sel = icap_pkg::CMD_WCFG;
            icap_pkg::ST_DESYNC:     word_sel = icap_pkg::CMD_DESYNC;
            icap_pkg::ST_FAR_HDR:    word_sel = icap_pkg::FAR_HDR;
            icap_pkg::ST_FAR:        word_sel = frame_addr_i;      // held by cfg block
            icap_pkg::ST_FDRI_HDR:   word_sel = icap_pkg::FDRI_HDR;
            icap_pkg::ST_FRAME_DATA: word_sel = fill_word_i;
            default:                 word_sel = '0;                // idle, select, preamble
        endcase
    end

    ////////////////////////////////////////////////////////////
    // registered port outputs
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csib_q  <= 1'b1;
            rdwrb_q <= 1'b1;
            data_q  <= '0;
        end else begin
            csib_q  <= (state_q == icap_pkg::ST_IDLE) || (state_q == icap_pkg::ST_SELECT);
            rdwrb_q <= (state_q == icap_pkg::ST_IDLE);
            data_q  <= icap_pkg::byte_bitrev(word_sel);
        end
    end

    // done lines up with csib going high again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            last_q <= (state_q == icap_pkg::ST_NOOP_D) && (state_d == icap_pkg::ST_IDLE);
            done_q <= last_q;
        end
    end

    assign csib_o       = csib_q;
    assign rdwrb_o      = rdwrb_q;
    assign icap_data_o  = data_q;
    assign frame_done_o = done_q;

endmodule

//--- frame_cfg_regs.sv
`timescale 1ns/1ps

module frame_cfg_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_accept_i,   // latch strobe from sequencer
    input  logic                         frame_done_i,     // step address
    input  logic                         load_addr_i,
    input  logic [icap_pkg::ICAP_W-1:0] frame_addr_i,
    input  logic [icap_pkg::ICAP_W-1:0] fill_word_i,
    output logic [icap_pkg::ICAP_W-1:0] frame_addr_o,
    output logic [icap_pkg::ICAP_W-1:0] fill_word_o
);

    logic [icap_pkg::ICAP_W-1:0] frame_addr_q;
    logic [icap_pkg::ICAP_W-1:0] fill_word_q;
    logic [icap_pkg::ICAP_W-1:0] addr_base;     // stored address after any step

    ////////////////////////////////////////////////////////////
    // frame address
    ////////////////////////////////////////////////////////////
    // a new start may land in the same cycle as the done strobe,
    // so the step is folded in before the load decision
    always_comb begin
        if (frame_done_i) begin
            addr_base = frame_addr_q + 1'b1;
        end else begin
            addr_base = frame_addr_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_addr_q <= '0;
        end else if (start_accept_i && load_addr_i) begin
            frame_addr_q <= frame_addr_i;               // external address wins
        end else begin
            frame_addr_q <= addr_base;
        end
    end

    ////////////////////////////////////////////////////////////
    // fill word
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_word_q <= '0;
        end else if (start_accept_i) begin
            fill_word_q <= fill_word_i;                 // captured on every start
        end
    end

    assign frame_addr_o = frame_addr_q;
    assign fill_word_o  = fill_word_q;

endmodule

//--- icap_pkg.sv
package icap_pkg;

    ////////////////////////////////////////////////////////////
    // port geometry and frame size
    ////////////////////////////////////////////////////////////
    localparam int ICAP_W      = 32;                // port data width
    localparam int FRAME_WORDS = 202;               // words per frame write
    localparam int WORD_CNT_W  = 8;                 // holds 0..FRAME_WORDS-1

    // last count value of each multi-cycle state
    localparam logic [WORD_CNT_W-1:0] FRAME_LAST  = WORD_CNT_W'(FRAME_WORDS - 1);
    localparam logic [WORD_CNT_W-1:0] NOOP_A_LAST = WORD_CNT_W'(2);    // three no-ops
    localparam logic [WORD_CNT_W-1:0] NOOP_C_LAST = WORD_CNT_W'(1);    // two no-ops
    localparam logic [WORD_CNT_W-1:0] NOOP_D_LAST = WORD_CNT_W'(1);    // two no-ops

    ////////////////////////////////////////////////////////////
    // configuration packet words
    ////////////////////////////////////////////////////////////
    localparam logic [ICAP_W-1:0] DUMMY_WORD    = 32'hFFFF_FFFF;
    localparam logic [ICAP_W-1:0] SYNC_WORD     = 32'hAA99_5566;
    localparam logic [ICAP_W-1:0] NOOP_WORD     = 32'h2000_0000;   // type-1 no-op
    localparam logic [ICAP_W-1:0] IDCODE_HDR    = 32'h3001_8001;   // write 1 word to IDCODE
    localparam logic [ICAP_W-1:0] DEVICE_IDCODE = 32'h0362_D093;
    localparam logic [ICAP_W-1:0] CMD_HDR       = 32'h3000_8001;   // write 1 word to CMD
    localparam logic [ICAP_W-1:0] CMD_WCFG      = 32'h0000_0001;
    localparam logic [ICAP_W-1:0] CMD_DESYNC    = 32'h0000_000D;
    localparam logic [ICAP_W-1:0] FAR_HDR       = 32'h3000_2001;   // write 1 word to FAR
    localparam logic [ICAP_W-1:0] FDRI_HDR      = 32'h3000_40CA;   // count 0xCA = 202 words

    ////////////////////////////////////////////////////////////
    // sequencer states, in stream order
    ////////////////////////////////////////////////////////////
    typedef enum logic [5:0] {
        ST_IDLE,
        ST_SELECT,        // rdwrb low, csib still high
        ST_PREAMBLE,      // first enabled word, zero
        ST_DUMMY,
        ST_SYNC,
        ST_NOOP_A,
        ST_IDCODE_HDR,
        ST_IDCODE,
        ST_CMD_HDR,
        ST_WCFG,
        ST_NOOP_B,
        ST_FAR_HDR,
        ST_FAR,
        ST_FDRI_HDR,
        ST_FRAME_DATA,
        ST_NOOP_C,
        ST_DESYNC_HDR,
        ST_DESYNC,
        ST_NOOP_D
    } seq_state_e;

    ////////////////////////////////////////////////////////////
    // byte bit-reversal
    ////////////////////////////////////////////////////////////
    // the port samples each byte msb-first on the lsb lane,
    // so every byte is mirrored in place
    function automatic logic [ICAP_W-1:0] byte_bitrev(input logic [ICAP_W-1:0] data);
        logic [ICAP_W-1:0] rev;
        int byte_idx;
        int bit_idx;
        rev = '0;
        for (byte_idx = 0; byte_idx < ICAP_W / 8; byte_idx++) begin
            for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
                rev[byte_idx * 8 + bit_idx] = data[byte_idx * 8 + (7 - bit_idx)];
            end
        end
        return rev;
    endfunction

endpackage
